/* city_distance.sv */
`timescale 1ns/10ps
`default_nettype none

module city_distance #(
	parameter int coord_bits = tsp_pkg::coord_bits_default
) (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   in_valid,
	input  wire  [coord_bits-1:0] ax,
	input  wire  [coord_bits-1:0] ay,
	input  wire  [coord_bits-1:0] bx,
	input  wire  [coord_bits-1:0] by,
	output logic                  out_valid,
	output logic [coord_bits:0]   distance
);

	logic [coord_bits-1:0] dx_q;
	logic [coord_bits-1:0] dy_q;
	logic v1_q;

	// Valid bits, two stages deep
	always_ff @(posedge clk) begin
		if (rst) begin
			v1_q <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			v1_q <= in_valid;
			out_valid <= v1_q;
		end
	end

	// Stage 1 absolute differences
	// Stage 2 sum, one extra bit for the carry
	always_ff @(posedge clk) begin
		dx_q <= (ax >= bx) ? ax - bx : bx - ax;
		dy_q <= (ay >= by) ? ay - by : by - ay;
		distance <= {1'b0, dx_q} + {1'b0, dy_q};
	end

endmodule

`default_nettype wire

/* city_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module city_ram #(
	parameter int coord_bits = tsp_pkg::coord_bits_default,
	parameter int node_addr_bits = tsp_pkg::node_addr_bits_default
) (
	input  wire                       clk,
	input  wire                       wr_en,
	input  wire  [node_addr_bits-1:0] wr_addr,
	input  wire  [coord_bits-1:0]     wr_x,
	input  wire  [coord_bits-1:0]     wr_y,
	input  wire  [node_addr_bits-1:0] rd_addr,
	output logic [coord_bits-1:0]     rd_x,
	output logic [coord_bits-1:0]     rd_y
);

	// One entry per city, Y in the upper half
	logic [2*coord_bits-1:0] mem [2**node_addr_bits];
	logic [2*coord_bits-1:0] rd_q;

	// Port A writes, port B reads one cycle later
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= {wr_y, wr_x};
		rd_q <= mem[rd_addr];
	end

	assign rd_x = rd_q[coord_bits-1:0];
	assign rd_y = rd_q[2*coord_bits-1:coord_bits];

endmodule

`default_nettype wire

/* project.f */
tsp_pkg.sv
city_ram.sv
city_distance.sv
tsp_file_parser.sv
tour_evaluator.sv
tsp_top.sv
tb_checker.sv
tb_tsp.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the TSP reader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_tsp -f project.f -o tb_tsp_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/tb_tsp_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
	exit 0
fi
exit 1

/* tb_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_checker #(
	parameter int len_bits = 21
) (
	input  wire                clk,
	input  wire                rst,
	input  wire                ready_to_read,
	input  wire                has_specdata,
	input  wire                tour_valid,
	input  wire [len_bits-1:0] tour_length,
	input  wire                exp_valid,
	input  wire [len_bits-1:0] exp_len,
	output int                 error_count,
	output int                 checked_count
);

	// Busy while a tour length is owed
	tsp_pkg::parse_state_t watch_phase;
	logic [len_bits-1:0] expected [$];
	logic [len_bits-1:0] want;
	logic first_cycle;

	////////////////////////////////////////////////////////////
	// Result and handshake checks on the rising edge
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (rst) begin
			watch_phase = tsp_pkg::ps_prolog;
			error_count = 0;
			checked_count = 0;
			first_cycle = 1'b1;
			expected.delete();
		end else begin
			// Both low in the first cycle out of reset
			if (first_cycle) begin
				if (ready_to_read !== 1'b0 || tour_valid !== 1'b0) begin
					$display("ERROR %0t: ready_to_read %b tour_valid %b right after reset",
						$time, ready_to_read, tour_valid);
					error_count++;
				end
				first_cycle = 1'b0;
			end
			if (exp_valid) begin
				expected.push_back(exp_len);
				watch_phase = tsp_pkg::ps_busy;
			end
			if (tour_valid) begin
				// Exactly one pulse per file
				if (expected.size() == 0) begin
					$display("ERROR %0t: tour_valid pulse with no file pending", $time);
					error_count++;
				end else begin
					want = expected.pop_front();
					checked_count++;
					if (tour_length !== want) begin
						$display("ERROR %0t: tour_length %0d, expected %0d",
							$time, tour_length, want);
						error_count++;
					end
				end
				watch_phase = tsp_pkg::ps_prolog;
			end else if (watch_phase == tsp_pkg::ps_busy && ready_to_read !== 1'b0) begin
				$display("ERROR %0t: ready_to_read high while a result is pending (byte held %b)",
					$time, has_specdata);
				error_count++;
			end
		end
	end

endmodule

`default_nettype wire

/* tb_tsp.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_tsp;

	////////////////////////////////////////////////////////////
	// Widths and run limits
	////////////////////////////////////////////////////////////

	localparam int coord_bits = tsp_pkg::coord_bits_default;
	localparam int node_addr_bits = tsp_pkg::node_addr_bits_default;
	localparam int len_bits = coord_bits + 1 + node_addr_bits;
	localparam int max_nodes = 2 ** node_addr_bits;
	localparam int num_cases = 8;
	localparam int timeout_cycles = 2000;

	logic clk;
	logic rst;
	logic [7:0] specdata;
	logic has_specdata;
	logic ready_to_read;
	logic [len_bits-1:0] tour_length;
	logic tour_valid;

	// Expected result handed to the checker after each EOF
	logic exp_valid;
	logic [len_bits-1:0] exp_len;
	int error_count;
	int checked_count;

	int seed;
	int fail_count;
	bit timed_out;

	// One case table row per file
	int row_n [num_cases];
	int row_x [num_cases][max_nodes];
	int row_y [num_cases][max_nodes];
	int row_exp [num_cases];

	// Bytes of the file being sent
	logic [7:0] text [$];
	int eof_idx;

	tsp_top #(
		.coord_bits(coord_bits),
		.node_addr_bits(node_addr_bits)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.specdata(specdata),
		.has_specdata(has_specdata),
		.ready_to_read(ready_to_read),
		.tour_length(tour_length),
		.tour_valid(tour_valid)
	);

	tb_checker #(
		.len_bits(len_bits)
	) chk0 (
		.clk(clk),
		.rst(rst),
		.ready_to_read(ready_to_read),
		.has_specdata(has_specdata),
		.tour_valid(tour_valid),
		.tour_length(tour_length),
		.exp_valid(exp_valid),
		.exp_len(exp_len),
		.error_count(error_count),
		.checked_count(checked_count)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reference model and table
	////////////////////////////////////////////////////////////

	function automatic int abs_diff(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	// Each city to the next and the last back to city 0
	function automatic int closed_tour_len(input int k);
		int sum;
		int i;
		int j;
		sum = 0;
		for (i = 0; i < row_n[k]; i++) begin
			j = (i + 1) % row_n[k];
			sum += abs_diff(row_x[k][i], row_x[k][j]);
			sum += abs_diff(row_y[k][i], row_y[k][j]);
		end
		return sum;
	endfunction

	task automatic set_city(input int k, input int i, input int x, input int y);
		row_x[k][i] = x;
		row_y[k][i] = y;
	endtask

	task automatic build_table();
		int k;
		int i;
		int x;
		int y;
		// Square with side 5
		row_n[0] = 4;
		set_city(0, 0, 0, 0);
		set_city(0, 1, 5, 0);
		set_city(0, 2, 5, 5);
		set_city(0, 3, 0, 5);
		// Two cities with one leg each way
		row_n[1] = 2;
		set_city(1, 0, 3, 7);
		set_city(1, 1, 10, 2);
		// Single city
		row_n[2] = 1;
		set_city(2, 0, 42, 9);
		// Random rows with the first one filling the memory
		for (k = 3; k < num_cases; k++) begin
			row_n[k] = (k == 3) ? max_nodes : 2 + int'($unsigned($random(seed)) % 15);
			for (i = 0; i < row_n[k]; i++) begin
				x = $random(seed) & 32'hffff;
				y = $random(seed) & 32'hffff;
				set_city(k, i, x, y);
			end
		end
		for (k = 0; k < num_cases; k++)
			row_exp[k] = closed_tour_len(k);
	endtask

	////////////////////////////////////////////////////////////
	// File text
	////////////////////////////////////////////////////////////

	task automatic push_str(input string s);
		int i;
		for (i = 0; i < s.len(); i++)
			text.push_back(s[i]);
	endtask

	// Unsigned decimal without leading zeros
	task automatic push_num(input int v);
		int digits [$];
		int i;
		if (v == 0)
			digits.push_back(0);
		while (v > 0) begin
			digits.push_front(v % 10);
			v = v / 10;
		end
		for (i = 0; i < digits.size(); i++)
			text.push_back(8'h30 + 8'(digits[i]));
	endtask

	// CR LF
	task automatic end_line();
		text.push_back(8'h0d);
		text.push_back(8'h0a);
	endtask

	task automatic build_file(input int k);
		int i;
		text.delete();
		push_str("NAME : case");
		push_num(k);
		end_line();
		push_str("TYPE : TSP");
		end_line();
		push_str("COMMENT : 3 fixed rows then random");
		end_line();
		end_line();
		push_str("DIMENSION : ");
		push_num(row_n[k]);
		end_line();
		push_str("EDGE_WEIGHT_TYPE : MAN_2D");
		end_line();
		push_str("NODE_COORD_SECTION");
		end_line();
		for (i = 0; i < row_n[k]; i++) begin
			push_num(i + 1);
			push_str(" ");
			push_num(row_x[k][i]);
			push_str(" ");
			push_num(row_y[k][i]);
			end_line();
		end
		push_str("EOF");
		text.push_back(8'h0d);
		eof_idx = text.size() - 1;
		// This LF waits at the input until the result is out
		text.push_back(8'h0a);
	endtask

	////////////////////////////////////////////////////////////
	// Byte stream driver
	////////////////////////////////////////////////////////////

	task automatic step_cycle();
		@(posedge clk);
		#1;
		exp_valid = 1'b0;
	endtask

	// A high ready_to_read here means the next edge takes the byte
	task automatic send_byte(input logic [7:0] b);
		int waited;
		waited = 0;
		specdata = b;
		has_specdata = 1'b1;
		while (ready_to_read !== 1'b1 && waited < timeout_cycles) begin
			step_cycle();
			waited++;
		end
		if (ready_to_read !== 1'b1) begin
			$display("Timeout: byte 0x%02h was never accepted at %0t", b, $time);
			timed_out = 1'b1;
			return;
		end
		step_cycle();
	endtask

	task automatic send_file(input int k);
		int i;
		build_file(k);
		for (i = 0; i < text.size(); i++) begin
			send_byte(text[i]);
			if (timed_out)
				return;
			if (i == eof_idx) begin
				exp_len = len_bits'(row_exp[k]);
				exp_valid = 1'b1;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int k;
		int waited;
		seed = 32'hb3a3;
		fail_count = 0;
		timed_out = 1'b0;
		rst = 1'b1;
		specdata = 8'h00;
		has_specdata = 1'b0;
		exp_valid = 1'b0;
		exp_len = '0;
		eof_idx = 0;
		build_table();

		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		waited = 0;
		while (ready_to_read !== 1'b1 && waited < timeout_cycles) begin
			step_cycle();
			waited++;
		end
		if (ready_to_read !== 1'b1) begin
			$display("Timeout: ready_to_read never went high after reset");
			timed_out = 1'b1;
		end

		// Next file waits on the pending result
		for (k = 0; k < num_cases && !timed_out; k++)
			send_file(k);
		has_specdata = 1'b0;

		waited = 0;
		while (!timed_out && checked_count < num_cases && waited < timeout_cycles) begin
			step_cycle();
			waited++;
		end
		if (!timed_out && checked_count < num_cases) begin
			$display("Timeout: only %0d of %0d tour lengths were reported",
				checked_count, num_cases);
			timed_out = 1'b1;
		end

		// Idle time to catch a stray extra pulse
		if (!timed_out)
			repeat (20) step_cycle();
		if (timed_out)
			fail_count++;

		$display("Checker errors %0d, other failures %0d, results %0d of %0d",
			error_count, fail_count, checked_count, num_cases);
		if (error_count == 0 && fail_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* tour_evaluator.sv */
`timescale 1ns/10ps
`default_nettype none

module tour_evaluator #(
	parameter int coord_bits = tsp_pkg::coord_bits_default,
	parameter int node_addr_bits = tsp_pkg::node_addr_bits_default
) (
	input  wire                                clk,
	input  wire                                rst,
	input  wire                                start,
	input  wire  [node_addr_bits:0]            node_count,
	input  wire  [coord_bits-1:0]              rd_x,
	input  wire  [coord_bits-1:0]              rd_y,
	input  wire                                out_valid,
	input  wire  [coord_bits:0]                distance,
	output logic [node_addr_bits-1:0]          rd_addr,
	output logic                               in_valid,
	output logic [coord_bits-1:0]              ax,
	output logic [coord_bits-1:0]              ay,
	output logic [coord_bits-1:0]              bx,
	output logic [coord_bits-1:0]              by,
	output logic                               done,
	output logic [coord_bits+node_addr_bits:0] total
);

	// Read side
	logic issuing;
	logic rd_valid;
	logic have_prev;
	logic [node_addr_bits:0] issue_cnt;
	// Result side
	logic [node_addr_bits:0] ret_cnt;
	// Previous city on the tour
	logic [coord_bits-1:0] prev_x;
	logic [coord_bits-1:0] prev_y;

	////////////////////////////////////////////////////////////
	// Address walk and accumulation
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			issuing <= 1'b0;
			rd_valid <= 1'b0;
			have_prev <= 1'b0;
			in_valid <= 1'b0;
			done <= 1'b0;
			issue_cnt <= '0;
			ret_cnt <= '0;
			rd_addr <= '0;
			total <= '0;
		end else begin
			done <= 1'b0;
			// RAM data is valid one cycle after the address
			rd_valid <= issuing;
			in_valid <= rd_valid && have_prev;
			if (rd_valid)
				have_prev <= 1'b1;

			// Addresses 0..n-1, then 0 again to close the tour
			if (issuing) begin
				issue_cnt <= issue_cnt + 1'b1;
				if (issue_cnt == node_count)
					issuing <= 1'b0;
				if (issue_cnt + 1'b1 == node_count)
					rd_addr <= '0;
				else
					rd_addr <= rd_addr + 1'b1;
			end

			// n legs in a closed tour
			if (out_valid) begin
				total <= total + distance;
				ret_cnt <= ret_cnt + 1'b1;
				if (ret_cnt + 1'b1 == node_count)
					done <= 1'b1;
			end

			if (start) begin
				total <= '0;
				ret_cnt <= '0;
				issue_cnt <= '0;
				rd_addr <= '0;
				have_prev <= 1'b0;
				issuing <= node_count != '0;
				// Empty tour finishes at once
				done <= node_count == '0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// City pairs into the distance pipe
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rd_valid) begin
			prev_x <= rd_x;
			prev_y <= rd_y;
			ax <= prev_x;
			ay <= prev_y;
			bx <= rd_x;
			by <= rd_y;
		end
	end

endmodule

`default_nettype wire

/* tsp_file_parser.sv */
`timescale 1ns/10ps
`default_nettype none

module tsp_file_parser #(
	parameter int coord_bits = tsp_pkg::coord_bits_default,
	parameter int node_addr_bits = tsp_pkg::node_addr_bits_default
) (
	input  wire                       clk,
	input  wire                       rst,
	input  wire  [7:0]                specdata,
	input  wire                       has_specdata,
	input  wire                       done,
	output logic                      ready_to_read,
	output logic                      wr_en,
	output logic [node_addr_bits-1:0] wr_addr,
	output logic [coord_bits-1:0]     wr_x,
	output logic [coord_bits-1:0]     wr_y,
	output logic                      start,
	output logic [node_addr_bits:0]   node_count
);

	// Accumulator wide enough for a coordinate and for the node count
	localparam int acc_bits = (coord_bits > node_addr_bits + 1) ? coord_bits : node_addr_bits + 1;

	tsp_pkg::parse_state_t phase;

	// Line context, 8'h00 means not seen yet
	logic [7:0] first_char;
	logic [7:0] second_char;
	logic [1:0] field_cnt;
	logic in_num;
	logic [acc_bits-1:0] acc;
	logic [node_addr_bits-1:0] addr_cnt;

	// Closed field values
	logic [acc_bits-1:0] last_num;
	logic [acc_bits-1:0] x_hold;
	logic [acc_bits-1:0] y_hold;

	logic take;
	logic is_digit;
	logic is_cr;
	logic is_lf;
	logic field_close;
	logic line_end;
	logic [3:0] digit_val;
	logic [acc_bits-1:0] line_last;
	logic [acc_bits-1:0] line_y;

	////////////////////////////////////////////////////////////
	// Byte classification
	////////////////////////////////////////////////////////////

	assign take = has_specdata & ready_to_read;
	assign is_cr = specdata == tsp_pkg::char_cr;
	assign is_lf = specdata == tsp_pkg::char_lf;
	assign is_digit = (specdata >= tsp_pkg::char_zero) && (specdata <= tsp_pkg::char_nine);
	assign digit_val = 4'(specdata - tsp_pkg::char_zero);

	// A non-digit right after a digit closes the field, CR included
	assign field_close = take && !is_lf && !is_digit && in_num;
	assign line_end = take && is_cr;

	// Last number of the line, may still sit in the accumulator at CR
	assign line_last = in_num ? acc : last_num;
	// Third number of a coordinate line
	assign line_y = (in_num && field_cnt == 2'd2) ? acc : y_hold;

	////////////////////////////////////////////////////////////
	// Control path
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= tsp_pkg::ps_prolog;
			ready_to_read <= 1'b0;
			first_char <= '0;
			second_char <= '0;
			field_cnt <= '0;
			in_num <= 1'b0;
			acc <= '0;
			addr_cnt <= '0;
			node_count <= '0;
			wr_en <= 1'b0;
			start <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			start <= 1'b0;
			ready_to_read <= 1'b1;

			if (take && !is_lf) begin
				// Decimal accumulate, acc*10 + digit
				if (is_digit) begin
					acc <= acc * acc_bits'(10) + acc_bits'(digit_val);
					in_num <= 1'b1;
				end else begin
					acc <= '0;
					in_num <= 1'b0;
					if (in_num && field_cnt != 2'd3)
						field_cnt <= field_cnt + 2'd1;
				end

				// Remember the leading two letters
				if (!is_cr) begin
					if (first_char == 8'h00)
						first_char <= specdata;
					else if (second_char == 8'h00)
						second_char <= specdata;
				end

				if (is_cr) begin
					first_char <= '0;
					second_char <= '0;
					field_cnt <= '0;
					case (phase)
						tsp_pkg::ps_prolog: begin
							if (first_char == tsp_pkg::char_d) begin
								node_count <= line_last[node_addr_bits:0];
							end else if (first_char == tsp_pkg::char_n &&
									second_char == tsp_pkg::char_o) begin
								phase <= tsp_pkg::ps_coordinates;
								addr_cnt <= '0;
							end
						end
						tsp_pkg::ps_coordinates: begin
							// EOF hands over to the evaluator
							if (first_char == tsp_pkg::char_e) begin
								phase <= tsp_pkg::ps_busy;
								start <= 1'b1;
								ready_to_read <= 1'b0;
							end else if (first_char != 8'h00) begin
								wr_en <= 1'b1;
								addr_cnt <= addr_cnt + 1'b1;
							end
						end
						default: begin
						end
					endcase
				end
			end

			// Hold off the source until the tour length is out
			if (phase == tsp_pkg::ps_busy) begin
				if (done)
					phase <= tsp_pkg::ps_prolog;
				else
					ready_to_read <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Field values and write data
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (field_close) begin
			last_num <= acc;
			// Second field is X, third is Y
			if (field_cnt == 2'd1)
				x_hold <= acc;
			if (field_cnt == 2'd2)
				y_hold <= acc;
		end
		if (line_end) begin
			wr_addr <= addr_cnt;
			wr_x <= x_hold[coord_bits-1:0];
			wr_y <= line_y[coord_bits-1:0];
		end
	end

endmodule

`default_nettype wire

/* tsp_pkg.sv */
`default_nettype none

package tsp_pkg;

	////////////////////////////////////////////////////////////
	// Character codes seen in the input stream
	////////////////////////////////////////////////////////////

	// Line terminators, CR ends a line and LF is skipped
	localparam logic [7:0] char_cr = 8'h0d;
	localparam logic [7:0] char_lf = 8'h0a;

	// Decimal digit bounds
	localparam logic [7:0] char_zero = 8'h30;
	localparam logic [7:0] char_nine = 8'h39;

	// Leading letters of DIMENSION, NODE_COORD_SECTION and EOF
	localparam logic [7:0] char_d = 8'h44;
	localparam logic [7:0] char_n = 8'h4e;
	localparam logic [7:0] char_e = 8'h45;

	// Second letter of NODE_COORD_SECTION, NAME also starts with N
	localparam logic [7:0] char_o = 8'h4f;

	////////////////////////////////////////////////////////////
	// Parser phase and default widths
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ps_prolog      = 2'd0,
		ps_coordinates = 2'd1,
		ps_busy        = 2'd2
	} parse_state_t;

	// 16 bit X/Y, 16 cities
	localparam int coord_bits_default = 16;
	localparam int node_addr_bits_default = 4;

endpackage

`default_nettype wire

/* tsp_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tsp_top #(
	parameter int coord_bits = tsp_pkg::coord_bits_default,
	parameter int node_addr_bits = tsp_pkg::node_addr_bits_default
) (
	input  wire                                clk,
	input  wire                                rst,
	input  wire  [7:0]                         specdata,
	input  wire                                has_specdata,
	output logic                               ready_to_read,
	output logic [coord_bits+node_addr_bits:0] tour_length,
	output logic                               tour_valid
);

	// One leg, then n legs summed
	localparam int dist_bits = coord_bits + 1;
	localparam int len_bits = dist_bits + node_addr_bits;

	// Parser to RAM
	logic wr_en;
	logic [node_addr_bits-1:0] wr_addr;
	logic [coord_bits-1:0] wr_x;
	logic [coord_bits-1:0] wr_y;

	// Parser and evaluator handshake
	logic start;
	logic done;
	logic [node_addr_bits:0] node_count;
	logic [len_bits-1:0] total;

	// Evaluator to RAM and distance pipe
	logic [node_addr_bits-1:0] rd_addr;
	logic [coord_bits-1:0] rd_x;
	logic [coord_bits-1:0] rd_y;
	logic in_valid;
	logic [coord_bits-1:0] ax;
	logic [coord_bits-1:0] ay;
	logic [coord_bits-1:0] bx;
	logic [coord_bits-1:0] by;
	logic out_valid;
	logic [dist_bits-1:0] distance;

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	tsp_file_parser #(
		.coord_bits(coord_bits),
		.node_addr_bits(node_addr_bits)
	) parser0 (
		.clk(clk),
		.rst(rst),
		.specdata(specdata),
		.has_specdata(has_specdata),
		.done(done),
		.ready_to_read(ready_to_read),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_x(wr_x),
		.wr_y(wr_y),
		.start(start),
		.node_count(node_count)
	);

	city_ram #(
		.coord_bits(coord_bits),
		.node_addr_bits(node_addr_bits)
	) ram0 (
		.clk(clk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_x(wr_x),
		.wr_y(wr_y),
		.rd_addr(rd_addr),
		.rd_x(rd_x),
		.rd_y(rd_y)
	);

	city_distance #(
		.coord_bits(coord_bits)
	) dist0 (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.ax(ax),
		.ay(ay),
		.bx(bx),
		.by(by),
		.out_valid(out_valid),
		.distance(distance)
	);

	tour_evaluator #(
		.coord_bits(coord_bits),
		.node_addr_bits(node_addr_bits)
	) eval0 (
		.clk(clk),
		.rst(rst),
		.start(start),
		.node_count(node_count),
		.rd_x(rd_x),
		.rd_y(rd_y),
		.out_valid(out_valid),
		.distance(distance),
		.rd_addr(rd_addr),
		.in_valid(in_valid),
		.ax(ax),
		.ay(ay),
		.bx(bx),
		.by(by),
		.done(done),
		.total(total)
	);

	////////////////////////////////////////////////////////////
	// Result register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst)
			tour_valid <= 1'b0;
		else
			tour_valid <= done;
	end

	// Held until the next file is evaluated
	always_ff @(posedge clk) begin
		if (done)
			tour_length <= total;
	end

endmodule

`default_nettype wire
